// ==== rtl/rvv_de_field_decode.sv ====
`timescale 1ns/100ps

module rvv_de_field_decode (
  input  logic [rvv_de_pkg::INST_WIDTH-1:0] inst,
  input  rvv_de_pkg::vsew_e                 vsew,
  input  rvv_de_pkg::vlmul_e                vlmul,
  input  logic                              vill,
  output logic                              legal,
  output rvv_de_pkg::opi_funct6_e           funct6,
  output rvv_de_pkg::emul_t                 emul_vd,
  output rvv_de_pkg::emul_t                 emul_vs2,
  output rvv_de_pkg::emul_t                 emul_max,
  output rvv_de_pkg::eew_e                  eew_vd,
  output rvv_de_pkg::eew_e                  eew_vs2,
  output rvv_de_pkg::eew_e                  eew_imm,
  output rvv_de_pkg::exe_unit_e             exe_unit
);

  import rvv_de_pkg::*;

  funct3_e   funct3;
  logic      vm;
  vreg_idx_t vs2;
  vreg_idx_t vs1;
  vreg_idx_t vd;
  logic      opivi;
  logic      known_op;
  logic      mask_op;
  logic      narrow_op;
  logic      nrr_op;
  emul_t     emul_lmul;
  emul_t     emul_nrr;
  eew_e      eew_sew;
  eew_e      eew_sew2;
  logic      vd_misaligned;
  logic      vs2_misaligned;

  assign funct6 = opi_funct6_e'(inst[26:21]);
  assign vm     = inst[20];
  assign vs2    = inst[19:15];
  assign vs1    = inst[14:10];
  assign funct3 = funct3_e'(inst[9:7]);
  assign vd     = inst[6:2];
  assign opivi  = (funct3 == OPIVI);

  // op class and target unit
  always_comb begin
    known_op  = 1'b1;
    mask_op   = 1'b0;
    narrow_op = 1'b0;
    nrr_op    = 1'b0;
    exe_unit  = ALU;
    case (funct6)
      VADD, VRSUB, VADC, VAND, VOR, VXOR, VSLL, VSRL, VSRA,
      VMERGE_VMV, VSADDU, VSADD, VSSRL, VSSRA: exe_unit = ALU;
      VMADC, VMSEQ, VMSNE, VMSLEU, VMSLE, VMSGTU, VMSGT: mask_op = 1'b1;
      VNSRL, VNSRA, VNCLIPU, VNCLIP: narrow_op = 1'b1;
      VSMUL_VMVNRR: nrr_op = 1'b1;
      VSLIDEUP, VSLIDEDOWN, VRGATHER: exe_unit = PMTRDT;
      default: known_op = 1'b0;
    endcase
    if (!opivi || !known_op) begin
      exe_unit = NONE;
    end
  end

  // fractional lmul still takes one register
  always_comb begin
    case (vlmul)
      LMUL1_4, LMUL1_2, LMUL1: emul_lmul = 4'd1;
      LMUL2:   emul_lmul = 4'd2;
      LMUL4:   emul_lmul = 4'd4;
      LMUL8:   emul_lmul = 4'd8;
      default: emul_lmul = 4'd0;
    endcase
  end

  // vmv<nr>r group size from vs1
  always_comb begin
    case (vs1[2:0])
      3'd0:    emul_nrr = 4'd1;
      3'd1:    emul_nrr = 4'd2;
      3'd3:    emul_nrr = 4'd4;
      3'd7:    emul_nrr = 4'd8;
      default: emul_nrr = 4'd0;
    endcase
  end

  always_comb begin
    emul_vd  = emul_lmul;
    emul_vs2 = emul_lmul;
    if (!opivi || !known_op) begin
      emul_vd  = '0;
      emul_vs2 = '0;
    end else if (mask_op) begin
      emul_vd = 4'd1;
    end else if (narrow_op) begin
      // vs2 is twice as wide as vd
      case (vlmul)
        LMUL1_4, LMUL1_2: emul_vs2 = 4'd1;
        LMUL1:   emul_vs2 = 4'd2;
        LMUL2:   emul_vs2 = 4'd4;
        LMUL4:   emul_vs2 = 4'd8;
        default: begin
          emul_vd  = '0;
          emul_vs2 = '0;
        end
      endcase
    end else if (nrr_op) begin
      emul_vd  = emul_nrr;
      emul_vs2 = emul_nrr;
    end
  end

  assign emul_max = (emul_vs2 > emul_vd) ? emul_vs2 : emul_vd;

  always_comb begin
    case (vsew)
      SEW8: begin
        eew_sew  = EEW8;
        eew_sew2 = EEW16;
      end
      SEW16: begin
        eew_sew  = EEW16;
        eew_sew2 = EEW32;
      end
      SEW32: begin
        eew_sew  = EEW32;
        eew_sew2 = EEW_NONE;
      end
      default: begin
        eew_sew  = EEW_NONE;
        eew_sew2 = EEW_NONE;
      end
    endcase
  end

  always_comb begin
    eew_vd  = eew_sew;
    eew_vs2 = eew_sew;
    eew_imm = eew_sew;
    if (!opivi || !known_op) begin
      eew_vd  = EEW_NONE;
      eew_vs2 = EEW_NONE;
      eew_imm = EEW_NONE;
    end else if (mask_op) begin
      eew_vd = EEW1;
    end else if (narrow_op) begin
      eew_vs2 = eew_sew2;
    end
  end

  // register group base must sit on an emul boundary
  assign vd_misaligned  = |(vd[3:0] & (emul_vd - 4'd1));
  assign vs2_misaligned = |(vs2[3:0] & (emul_vs2 - 4'd1));

  always_comb begin
    legal = opivi && known_op && !vill && (emul_max != '0) && (eew_sew != EEW_NONE);
    if (funct6 == VADC && vm) begin
      legal = 1'b0;
    end
    // vmv.v.i form needs vs2 zero
    if (funct6 == VMERGE_VMV && vm && vs2 != '0) begin
      legal = 1'b0;
    end
    if (nrr_op && (!vm || vs1[4:3] != 2'b00)) begin
      legal = 1'b0;
    end
    if (narrow_op && (vsew == SEW32 || vlmul == LMUL8)) begin
      legal = 1'b0;
    end
    if (vd_misaligned || vs2_misaligned) begin
      legal = 1'b0;
    end
  end

endmodule

// ==== rtl/rvv_de_pkg.sv ====
package rvv_de_pkg;

  parameter int XLEN               = 32;
  parameter int INST_WIDTH         = 27;
  parameter int REG_IDX_WIDTH      = 5;
  parameter int UOP_INDEX_WIDTH    = 3;
  parameter int EMUL_WIDTH         = 4;
  parameter int IMM_WIDTH          = 5;
  parameter int NUM_DE_UOP_DEFAULT = 2;

  typedef logic [REG_IDX_WIDTH-1:0]   vreg_idx_t;
  typedef logic [UOP_INDEX_WIDTH-1:0] uop_index_t;
  typedef logic [EMUL_WIDTH-1:0]      emul_t;
  typedef logic [XLEN-1:0]            xdata_t;

  typedef enum logic [2:0] {
    OPIVV = 3'b000,
    OPFVV = 3'b001,
    OPMVV = 3'b010,
    OPIVI = 3'b011,
    OPIVX = 3'b100,
    OPFVF = 3'b101,
    OPMVX = 3'b110,
    OPCFG = 3'b111
  } funct3_e;

  // RVV funct6 encodings of the OPIVI group
  typedef enum logic [5:0] {
    VADD         = 6'b000000,
    VRSUB        = 6'b000011,
    VAND         = 6'b001001,
    VOR          = 6'b001010,
    VXOR         = 6'b001011,
    VRGATHER     = 6'b001100,
    VSLIDEUP     = 6'b001110,
    VSLIDEDOWN   = 6'b001111,
    VADC         = 6'b010000,
    VMADC        = 6'b010001,
    VMERGE_VMV   = 6'b010111,
    VMSEQ        = 6'b011000,
    VMSNE        = 6'b011001,
    VMSLEU       = 6'b011100,
    VMSLE        = 6'b011101,
    VMSGTU       = 6'b011110,
    VMSGT        = 6'b011111,
    VSADDU       = 6'b100000,
    VSADD        = 6'b100001,
    VSLL         = 6'b100101,
    VSMUL_VMVNRR = 6'b100111,
    VSRL         = 6'b101000,
    VSRA         = 6'b101001,
    VSSRL        = 6'b101010,
    VSSRA        = 6'b101011,
    VNSRL        = 6'b101100,
    VNSRA        = 6'b101101,
    VNCLIPU      = 6'b101110,
    VNCLIP       = 6'b101111
  } opi_funct6_e;

  typedef enum logic [2:0] {
    SEW8  = 3'b000,
    SEW16 = 3'b001,
    SEW32 = 3'b010
  } vsew_e;

  typedef enum logic [2:0] {
    LMUL1_4 = 3'b110,
    LMUL1_2 = 3'b111,
    LMUL1   = 3'b000,
    LMUL2   = 3'b001,
    LMUL4   = 3'b010,
    LMUL8   = 3'b011
  } vlmul_e;

  typedef enum logic [2:0] {
    EEW_NONE,
    EEW1,
    EEW8,
    EEW16,
    EEW32
  } eew_e;

  typedef enum logic [1:0] {
    NONE,
    ALU,
    PMTRDT
  } exe_unit_e;

  typedef enum logic [1:0] {
    S_IDLE,
    S_SEND,
    S_WAIT_ACK_LOW,
    S_DONE
  } seq_state_e;

endpackage

// ==== rtl/rvv_de_sequencer.sv ====
`timescale 1ns/100ps

module rvv_de_sequencer #(
  parameter int NUM_DE_UOP = rvv_de_pkg::NUM_DE_UOP_DEFAULT
) (
  input  logic                              clk,
  input  logic                              rst,
  input  logic                              inst_req,
  input  logic [rvv_de_pkg::INST_WIDTH-1:0] inst,
  input  rvv_de_pkg::vsew_e                 vsew,
  input  rvv_de_pkg::vlmul_e                vlmul,
  input  logic                              vill,
  input  logic                              legal,
  input  logic                              group_last,
  input  logic                              uop_ack,
  output logic                              inst_ack,
  output logic                              inst_illegal,
  output logic [rvv_de_pkg::INST_WIDTH-1:0] inst_q,
  output rvv_de_pkg::vsew_e                 vsew_q,
  output rvv_de_pkg::vlmul_e                vlmul_q,
  output logic                              vill_q,
  output rvv_de_pkg::uop_index_t            uop_base,
  output logic                              uop_req
);

  import rvv_de_pkg::*;

  seq_state_e state;
  logic       capture;

  // idle is only reached once inst_ack has dropped
  assign capture = (state == S_IDLE) && inst_req;

  always_ff @(posedge clk) begin
    if (rst) begin
      state    <= S_IDLE;
      inst_ack <= 1'b0;
      uop_base <= '0;
      inst_q   <= '0;
      vsew_q   <= SEW8;
      vlmul_q  <= LMUL1;
      vill_q   <= 1'b0;
    end else begin
      if (capture) begin
        inst_ack <= 1'b1;
      end else if (inst_ack && !inst_req) begin
        inst_ack <= 1'b0;
      end

      case (state)
        S_IDLE: begin
          if (capture) begin
            inst_q   <= inst;
            vsew_q   <= vsew;
            vlmul_q  <= vlmul;
            vill_q   <= vill;
            uop_base <= '0;
            state    <= S_SEND;
          end
        end
        S_SEND: begin
          if (!legal) begin
            state <= S_DONE;
          end else if (uop_ack) begin
            state <= S_WAIT_ACK_LOW;
          end
        end
        S_WAIT_ACK_LOW: begin
          if (!uop_ack) begin
            uop_base <= uop_base + UOP_INDEX_WIDTH'(NUM_DE_UOP);
            state    <= group_last ? S_DONE : S_SEND;
          end
        end
        S_DONE: begin
          // let the instruction handshake finish
          if (!inst_ack) begin
            state <= S_IDLE;
          end
        end
        default: state <= S_IDLE;
      endcase
    end
  end

  assign uop_req      = (state == S_SEND) && legal;
  assign inst_illegal = inst_ack && !legal;

  a_uop_req_held: assert property (
    @(posedge clk) disable iff (rst) $fell(uop_req) |-> $past(uop_ack)
  ) else $error("uop_req dropped before uop_ack");

  a_inst_q_stable: assert property (
    @(posedge clk) disable iff (rst) (uop_req && $past(uop_req)) |-> $stable(inst_q)
  ) else $error("captured instruction changed during uop_req");

  a_ack_from_idle: assert property (
    @(posedge clk) disable iff (rst) $rose(inst_ack) |-> ($past(state) == S_IDLE)
  ) else $error("inst_ack raised outside idle");

endmodule

// ==== rtl/rvv_de_uop_gen.sv ====
`timescale 1ns/100ps

module rvv_de_uop_gen #(
  parameter int NUM_DE_UOP = rvv_de_pkg::NUM_DE_UOP_DEFAULT
) (
  input  logic [rvv_de_pkg::INST_WIDTH-1:0]         inst,
  input  rvv_de_pkg::opi_funct6_e                   funct6,
  input  rvv_de_pkg::emul_t                         emul_vd,
  input  rvv_de_pkg::emul_t                         emul_max,
  input  rvv_de_pkg::eew_e                          eew_vd,
  input  rvv_de_pkg::eew_e                          eew_vs2,
  input  rvv_de_pkg::eew_e                          eew_imm,
  input  rvv_de_pkg::exe_unit_e                     exe_unit,
  input  rvv_de_pkg::uop_index_t                    uop_base,
  output logic [NUM_DE_UOP-1:0]                     uop_valid,
  output rvv_de_pkg::uop_index_t [NUM_DE_UOP-1:0]   uop_index,
  output logic [NUM_DE_UOP-1:0]                     uop_last,
  output logic [NUM_DE_UOP-1:0]                     uop_v0_valid,
  output logic [NUM_DE_UOP-1:0]                     uop_vs3_valid,
  output rvv_de_pkg::vreg_idx_t [NUM_DE_UOP-1:0]    uop_vd_index,
  output rvv_de_pkg::vreg_idx_t [NUM_DE_UOP-1:0]    uop_vs2_index,
  output rvv_de_pkg::eew_e [NUM_DE_UOP-1:0]         uop_vd_eew,
  output rvv_de_pkg::eew_e [NUM_DE_UOP-1:0]         uop_vs2_eew,
  output rvv_de_pkg::xdata_t [NUM_DE_UOP-1:0]       uop_rs1_data,
  output rvv_de_pkg::opi_funct6_e [NUM_DE_UOP-1:0]  uop_funct6,
  output rvv_de_pkg::exe_unit_e [NUM_DE_UOP-1:0]    uop_exe_unit,
  output logic                                      group_last
);

  import rvv_de_pkg::*;

  localparam int SLOT_IDX_WIDTH = UOP_INDEX_WIDTH + 1;

  logic                 vm;
  vreg_idx_t            vs2;
  logic [IMM_WIDTH-1:0] imm;
  vreg_idx_t            vd;
  xdata_t               imm_data;
  logic                 mask_dst;
  logic                 v0_used;

  assign vm  = inst[20];
  assign vs2 = inst[19:15];
  assign imm = inst[14:10];
  assign vd  = inst[6:2];

  // mask results merge into the old vd, read as vs3
  assign mask_dst = (eew_vd == EEW1);
  assign v0_used  = (funct6 == VADC || funct6 == VMADC) && !vm;

  always_comb begin
    case (funct6)
      VADD, VRSUB, VADC, VMADC, VAND, VOR, VXOR, VMSEQ, VMSNE, VMSLEU,
      VMSLE, VMSGTU, VMSGT, VMERGE_VMV, VSADDU, VSADD: begin
        imm_data = {{(XLEN-IMM_WIDTH){imm[IMM_WIDTH-1]}}, imm};
      end
      VSLL, VSRL, VSRA, VSSRL, VSSRA: begin
        case (eew_imm)
          EEW8:    imm_data = xdata_t'(imm[2:0]);
          EEW16:   imm_data = xdata_t'(imm[3:0]);
          default: imm_data = xdata_t'(imm);
        endcase
      end
      VNSRL, VNSRA, VNCLIPU, VNCLIP: begin
        // log2(2*sew) bits, the field holds at most 5
        if (eew_imm == EEW8) begin
          imm_data = xdata_t'(imm[3:0]);
        end else begin
          imm_data = xdata_t'(imm);
        end
      end
      VSLIDEUP, VSLIDEDOWN, VRGATHER: imm_data = xdata_t'(imm);
      default: imm_data = '0;
    endcase
  end

  for (genvar k = 0; k < NUM_DE_UOP; k++) begin : g_slot
    logic [SLOT_IDX_WIDTH-1:0] idx;

    assign idx              = {1'b0, uop_base} + SLOT_IDX_WIDTH'(k);
    assign uop_valid[k]     = (idx < emul_max);
    assign uop_last[k]      = (idx == emul_max - 4'd1);
    assign uop_index[k]     = idx[UOP_INDEX_WIDTH-1:0];
    assign uop_vd_index[k]  = (emul_vd > 4'd1 && !mask_dst) ? vd + vreg_idx_t'(idx) : vd;
    assign uop_vs2_index[k] = vs2 + vreg_idx_t'(idx);
    assign uop_vd_eew[k]    = eew_vd;
    assign uop_vs2_eew[k]   = eew_vs2;
    assign uop_v0_valid[k]  = v0_used;
    assign uop_vs3_valid[k] = mask_dst;
    assign uop_rs1_data[k]  = imm_data;
    assign uop_funct6[k]    = funct6;
    assign uop_exe_unit[k]  = exe_unit;
  end

  assign group_last = |uop_last;

endmodule

// ==== rtl/rvv_decode_unit_ari.sv ====
`timescale 1ns/100ps

module rvv_decode_unit_ari #(
  parameter int NUM_DE_UOP = rvv_de_pkg::NUM_DE_UOP_DEFAULT
) (
  input  logic                                      clk,
  input  logic                                      rst,
  input  logic                                      inst_req,
  input  logic [rvv_de_pkg::INST_WIDTH-1:0]         inst,
  input  rvv_de_pkg::vsew_e                         vsew,
  input  rvv_de_pkg::vlmul_e                        vlmul,
  input  logic                                      vill,
  output logic                                      inst_ack,
  output logic                                      inst_illegal,
  output logic                                      uop_req,
  input  logic                                      uop_ack,
  output logic [NUM_DE_UOP-1:0]                     uop_valid,
  output rvv_de_pkg::uop_index_t [NUM_DE_UOP-1:0]   uop_index,
  output logic [NUM_DE_UOP-1:0]                     uop_last,
  output logic [NUM_DE_UOP-1:0]                     uop_v0_valid,
  output logic [NUM_DE_UOP-1:0]                     uop_vs3_valid,
  output rvv_de_pkg::vreg_idx_t [NUM_DE_UOP-1:0]    uop_vd_index,
  output rvv_de_pkg::vreg_idx_t [NUM_DE_UOP-1:0]    uop_vs2_index,
  output rvv_de_pkg::eew_e [NUM_DE_UOP-1:0]         uop_vd_eew,
  output rvv_de_pkg::eew_e [NUM_DE_UOP-1:0]         uop_vs2_eew,
  output rvv_de_pkg::xdata_t [NUM_DE_UOP-1:0]       uop_rs1_data,
  output rvv_de_pkg::opi_funct6_e [NUM_DE_UOP-1:0]  uop_funct6,
  output rvv_de_pkg::exe_unit_e [NUM_DE_UOP-1:0]    uop_exe_unit
);

  import rvv_de_pkg::*;

  logic [INST_WIDTH-1:0] inst_q;
  vsew_e                 vsew_q;
  vlmul_e                vlmul_q;
  logic                  vill_q;
  uop_index_t            uop_base;
  logic                  legal;
  logic                  group_last;
  opi_funct6_e           funct6;
  emul_t                 emul_vd;
  emul_t                 emul_max;
  eew_e                  eew_vd;
  eew_e                  eew_vs2;
  eew_e                  eew_imm;
  exe_unit_e             exe_unit;

  rvv_de_sequencer #(
    .NUM_DE_UOP (NUM_DE_UOP)
  ) u_sequencer (
    .clk          (clk),
    .rst          (rst),
    .inst_req     (inst_req),
    .inst         (inst),
    .vsew         (vsew),
    .vlmul        (vlmul),
    .vill         (vill),
    .legal        (legal),
    .group_last   (group_last),
    .uop_ack      (uop_ack),
    .inst_ack     (inst_ack),
    .inst_illegal (inst_illegal),
    .inst_q       (inst_q),
    .vsew_q       (vsew_q),
    .vlmul_q      (vlmul_q),
    .vill_q       (vill_q),
    .uop_base     (uop_base),
    .uop_req      (uop_req)
  );

  // vs2 group size only matters for legality inside the decoder
  rvv_de_field_decode u_field_decode (
    .inst     (inst_q),
    .vsew     (vsew_q),
    .vlmul    (vlmul_q),
    .vill     (vill_q),
    .legal    (legal),
    .funct6   (funct6),
    .emul_vd  (emul_vd),
    .emul_vs2 (),
    .emul_max (emul_max),
    .eew_vd   (eew_vd),
    .eew_vs2  (eew_vs2),
    .eew_imm  (eew_imm),
    .exe_unit (exe_unit)
  );

  rvv_de_uop_gen #(
    .NUM_DE_UOP (NUM_DE_UOP)
  ) u_uop_gen (
    .inst          (inst_q),
    .funct6        (funct6),
    .emul_vd       (emul_vd),
    .emul_max      (emul_max),
    .eew_vd        (eew_vd),
    .eew_vs2       (eew_vs2),
    .eew_imm       (eew_imm),
    .exe_unit      (exe_unit),
    .uop_base      (uop_base),
    .uop_valid     (uop_valid),
    .uop_index     (uop_index),
    .uop_last      (uop_last),
    .uop_v0_valid  (uop_v0_valid),
    .uop_vs3_valid (uop_vs3_valid),
    .uop_vd_index  (uop_vd_index),
    .uop_vs2_index (uop_vs2_index),
    .uop_vd_eew    (uop_vd_eew),
    .uop_vs2_eew   (uop_vs2_eew),
    .uop_rs1_data  (uop_rs1_data),
    .uop_funct6    (uop_funct6),
    .uop_exe_unit  (uop_exe_unit),
    .group_last    (group_last)
  );

endmodule

// ==== run_sim.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f rvv_decode_unit_ari.f \
  --top-module tb_rvv_decode_unit_ari -o sim_tb

./obj_dir/sim_tb | tee sim.log

if grep -qx "test passed" sim.log; then
  echo "simulation passed"
else
  echo "simulation failed"
  exit 1
fi

// ==== rvv_decode_unit_ari.f ====
rtl/rvv_de_pkg.sv
rtl/rvv_de_field_decode.sv
rtl/rvv_de_uop_gen.sv
rtl/rvv_de_sequencer.sv
rtl/rvv_decode_unit_ari.sv
verif/tb_rvv_decode_unit_ari.sv

// ==== verif/rvv_de_stimulus.txt ====
# funct6 vm vs2 imm funct3 vd vsew vlmul vill | legal uops exe vd_eew vs2_eew
# all hex; vsew, vlmul, exe and eew columns hold the raw enum codes
# vadd.vi at lmul1, negative immediate
00 1 04 1b 3 02 2 0 0 1 1 1 4 4
# vsaddu.vi at lmul8, four groups
20 1 10 07 3 08 0 3 0 1 8 1 2 2
# vmsleu.vi at lmul4, mask result
1c 1 0c 1f 3 01 1 2 0 1 4 1 1 3
# vnclip.wi at sew16 lmul2, then vslidedown.vi
2f 1 08 13 3 02 1 1 0 1 4 1 3 4
0f 1 04 1a 3 08 2 1 0 1 2 2 4 4
# vsrl.vi at lmul1/2
28 1 03 1d 3 05 0 7 0 1 1 1 2 2
# illegal: misaligned vd, vadc with vm=1, vill, opmvv, vmv<nr>r with vs1=2
00 1 04 00 3 03 0 1 0 0 0 0 0 0
10 1 04 01 3 06 0 0 0 0 0 0 0 0
00 1 04 02 3 02 0 0 1 0 0 0 0 0
00 1 04 02 2 02 0 0 0 0 0 0 0 0
27 1 08 02 3 08 0 0 0 0 0 0 0 0
# vmv4r.v, vadc.vim and vmadc.vim
27 1 08 03 3 04 0 0 0 1 4 1 2 2
10 0 04 05 3 06 1 0 0 1 1 1 3 3
11 0 02 03 3 01 0 1 0 1 2 1 1 2

// ==== verif/tb_rvv_decode_unit_ari.sv ====
`timescale 1ns/100ps

module tb_rvv_decode_unit_ari;

  import rvv_de_pkg::*;

  localparam int NUM_DE_UOP     = 2;
  localparam int TIMEOUT_CYCLES = 50;

  logic                             clk = 1'b0;
  logic                             rst;
  logic                             inst_req;
  logic [INST_WIDTH-1:0]            inst;
  vsew_e                            vsew;
  vlmul_e                           vlmul;
  logic                             vill;
  logic                             inst_ack;
  logic                             inst_illegal;
  logic                             uop_req;
  logic                             uop_ack;
  logic [NUM_DE_UOP-1:0]            uop_valid;
  uop_index_t [NUM_DE_UOP-1:0]      uop_index;
  logic [NUM_DE_UOP-1:0]            uop_last;
  logic [NUM_DE_UOP-1:0]            uop_v0_valid;
  logic [NUM_DE_UOP-1:0]            uop_vs3_valid;
  vreg_idx_t [NUM_DE_UOP-1:0]       uop_vd_index;
  vreg_idx_t [NUM_DE_UOP-1:0]       uop_vs2_index;
  eew_e [NUM_DE_UOP-1:0]            uop_vd_eew;
  eew_e [NUM_DE_UOP-1:0]            uop_vs2_eew;
  xdata_t [NUM_DE_UOP-1:0]          uop_rs1_data;
  opi_funct6_e [NUM_DE_UOP-1:0]     uop_funct6;
  exe_unit_e [NUM_DE_UOP-1:0]       uop_exe_unit;

  // one stimulus line, raw hex columns
  logic [31:0] st_funct6, st_vm, st_vs2, st_imm, st_funct3, st_vd;
  logic [31:0] st_vsew, st_vlmul, st_vill;
  logic [31:0] exp_legal, exp_uops, exp_exe, exp_vd_eew, exp_vs2_eew;

  int     errors;
  int     n_inst;
  int     fd;
  integer seed;
  logic   run_aborted;
  string  line;

  rvv_decode_unit_ari #(
    .NUM_DE_UOP (NUM_DE_UOP)
  ) u_dut (
    .clk           (clk),
    .rst           (rst),
    .inst_req      (inst_req),
    .inst          (inst),
    .vsew          (vsew),
    .vlmul         (vlmul),
    .vill          (vill),
    .inst_ack      (inst_ack),
    .inst_illegal  (inst_illegal),
    .uop_req       (uop_req),
    .uop_ack       (uop_ack),
    .uop_valid     (uop_valid),
    .uop_index     (uop_index),
    .uop_last      (uop_last),
    .uop_v0_valid  (uop_v0_valid),
    .uop_vs3_valid (uop_vs3_valid),
    .uop_vd_index  (uop_vd_index),
    .uop_vs2_index (uop_vs2_index),
    .uop_vd_eew    (uop_vd_eew),
    .uop_vs2_eew   (uop_vs2_eew),
    .uop_rs1_data  (uop_rs1_data),
    .uop_funct6    (uop_funct6),
    .uop_exe_unit  (uop_exe_unit)
  );

  always #2 clk = ~clk;

  task automatic check_legal(input logic got, input logic exp, input string what);
    if (got !== exp) begin
      errors++;
      $display("Error at %0t: %s is %0b, expected %0b", $time, what, got, exp);
    end
  endtask

  task automatic check_exe_unit(input exe_unit_e got, input exe_unit_e exp, input string what);
    if (got !== exp) begin
      errors++;
      $display("Error at %0t: %s is %0d, expected %0d", $time, what, got, exp);
    end
  endtask

  task automatic check_eew(input eew_e got, input eew_e exp, input string what);
    if (got !== exp) begin
      errors++;
      $display("Error at %0t: %s is %0d, expected %0d", $time, what, got, exp);
    end
  endtask

  task automatic check_vreg(input vreg_idx_t got, input vreg_idx_t exp, input string what);
    if (got !== exp) begin
      errors++;
      $display("Error at %0t: %s is v%0d, expected v%0d", $time, what, got, exp);
    end
  endtask

  task automatic check_data(input xdata_t got, input xdata_t exp, input string what);
    if (got !== exp) begin
      errors++;
      $display("Error at %0t: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_index(input uop_index_t got, input uop_index_t exp, input string what);
    if (got !== exp) begin
      errors++;
      $display("Error at %0t: %s is %0d, expected %0d", $time, what, got, exp);
    end
  endtask

  task automatic check_funct6(input opi_funct6_e got, input opi_funct6_e exp,
                              input string what);
    if (got !== exp) begin
      errors++;
      $display("Error at %0t: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic count_wait(inout int cnt, input string what);
    cnt++;
    if (cnt > TIMEOUT_CYCLES) begin
      $display("timeout: %s did not happen within %0d cycles", what, TIMEOUT_CYCLES);
      run_aborted = 1'b1;
    end
  endtask

  function automatic int lmul_regs(input vlmul_e lm);
    case (lm)
      LMUL2:   return 2;
      LMUL4:   return 4;
      LMUL8:   return 8;
      default: return 1;
    endcase
  endfunction

  function automatic xdata_t expected_rs1(input opi_funct6_e op, input logic [4:0] imm,
                                          input vsew_e sew);
    case (op)
      VSLL, VSRL, VSRA, VSSRL, VSSRA: begin
        if (sew == SEW8) return xdata_t'(imm[2:0]);
        if (sew == SEW16) return xdata_t'(imm[3:0]);
        return xdata_t'(imm);
      end
      // shift amount covers the double-width source
      VNSRL, VNSRA, VNCLIPU, VNCLIP: begin
        if (sew == SEW8) return xdata_t'(imm[3:0]);
        return xdata_t'(imm);
      end
      VSLIDEUP, VSLIDEDOWN, VRGATHER: return xdata_t'(imm);
      // whole-register move has no scalar operand
      VSMUL_VMVNRR: return '0;
      default: return $signed(imm);
    endcase
  endfunction

  task automatic check_group(input int base);
    int          idx;
    int          emul_vd;
    logic        mask_dst;
    opi_funct6_e op;
    vreg_idx_t   exp_vd;
    string       tag;
    op       = opi_funct6_e'(st_funct6[5:0]);
    mask_dst = (exp_vd_eew[2:0] == EEW1);
    emul_vd  = (op == VSMUL_VMVNRR) ? exp_uops : lmul_regs(vlmul_e'(st_vlmul[2:0]));
    for (int k = 0; k < NUM_DE_UOP; k++) begin
      idx = base + k;
      tag = $sformatf("inst %0d uop %0d", n_inst, idx);
      check_legal(uop_valid[k], idx < exp_uops, {tag, " valid"});
      check_legal(uop_last[k], idx == exp_uops - 1, {tag, " last"});
      if (idx < exp_uops) begin
        if (mask_dst || emul_vd <= 1) begin
          exp_vd = st_vd[4:0];
        end else begin
          exp_vd = vreg_idx_t'(st_vd + idx);
        end
        check_index(uop_index[k], uop_index_t'(idx), {tag, " index"});
        check_vreg(uop_vd_index[k], exp_vd, {tag, " vd"});
        check_vreg(uop_vs2_index[k], vreg_idx_t'(st_vs2 + idx), {tag, " vs2"});
        check_eew(uop_vd_eew[k], eew_e'(exp_vd_eew[2:0]), {tag, " vd eew"});
        check_eew(uop_vs2_eew[k], eew_e'(exp_vs2_eew[2:0]), {tag, " vs2 eew"});
        check_exe_unit(uop_exe_unit[k], exe_unit_e'(exp_exe[1:0]), {tag, " exe unit"});
        check_funct6(uop_funct6[k], op, {tag, " funct6"});
        check_data(uop_rs1_data[k], expected_rs1(op, st_imm[4:0], vsew_e'(st_vsew[2:0])),
                   {tag, " rs1 data"});
        check_legal(uop_vs3_valid[k], mask_dst, {tag, " vs3 valid"});
        check_legal(uop_v0_valid[k], (op == VADC || op == VMADC) && !st_vm[0],
                    {tag, " v0 valid"});
      end
    end
  endtask

  task automatic run_instruction();
    int cnt;
    int ngroups;
    int delay;
    n_inst++;
    @(posedge clk);
    inst     <= {st_funct6[5:0], st_vm[0], st_vs2[4:0], st_imm[4:0], st_funct3[2:0],
                 st_vd[4:0], 2'b00};
    vsew     <= vsew_e'(st_vsew[2:0]);
    vlmul    <= vlmul_e'(st_vlmul[2:0]);
    vill     <= st_vill[0];
    inst_req <= 1'b1;
    cnt = 0;
    while (inst_ack !== 1'b1 && !run_aborted) begin
      @(posedge clk);
      if (inst_ack !== 1'b1) check_legal(uop_req, 1'b0, "uop_req before inst_ack");
      count_wait(cnt, "inst_ack rising");
    end
    if (run_aborted) return;
    check_legal(inst_illegal, !exp_legal[0], $sformatf("inst %0d illegal", n_inst));
    inst_req <= 1'b0;

    if (exp_legal[0]) begin
      ngroups = (exp_uops + NUM_DE_UOP - 1) / NUM_DE_UOP;
      for (int g = 0; g < ngroups; g++) begin
        cnt = 0;
        while (uop_req !== 1'b1 && !run_aborted) begin
          @(posedge clk);
          count_wait(cnt, "uop_req rising");
        end
        if (run_aborted) return;
        check_group(g * NUM_DE_UOP);
        delay = $unsigned($random(seed)) % 4;
        if (delay != 0) begin
          repeat (delay) @(posedge clk);
          // back-pressure must not move the group
          check_legal(uop_req, 1'b1, "uop_req held under back-pressure");
          check_group(g * NUM_DE_UOP);
        end
        uop_ack <= 1'b1;
        cnt = 0;
        while (uop_req !== 1'b0 && !run_aborted) begin
          @(posedge clk);
          count_wait(cnt, "uop_req falling");
        end
        if (run_aborted) return;
        uop_ack <= 1'b0;
      end
    end

    cnt = 0;
    while (inst_ack !== 1'b0 && !run_aborted) begin
      @(posedge clk);
      if (!exp_legal[0]) check_legal(uop_req, 1'b0, "uop_req for illegal instruction");
      count_wait(cnt, "inst_ack falling");
    end
  endtask

  initial begin
    rst         <= 1'b1;
    inst_req    <= 1'b0;
    inst        <= '0;
    vsew        <= SEW8;
    vlmul       <= LMUL1;
    vill        <= 1'b0;
    uop_ack     <= 1'b0;
    errors      = 0;
    n_inst      = 0;
    run_aborted = 1'b0;
    seed        = 32'hb09f43af;
    fd = $fopen("verif/rvv_de_stimulus.txt", "r");
    if (fd == 0) begin
      $display("could not open the stimulus file verif/rvv_de_stimulus.txt");
      run_aborted = 1'b1;
    end
    repeat (5) @(posedge clk);
    rst <= 1'b0;

    // comment lines fail the scan and are skipped
    while (!run_aborted && $fgets(line, fd) > 0) begin
      if ($sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                  st_funct6, st_vm, st_vs2, st_imm, st_funct3, st_vd, st_vsew, st_vlmul,
                  st_vill, exp_legal, exp_uops, exp_exe, exp_vd_eew, exp_vs2_eew) == 14) begin
        run_instruction();
      end
    end
    if (fd != 0) $fclose(fd);

    if (!run_aborted) begin
      repeat (4) begin
        @(posedge clk);
        check_legal(uop_req, 1'b0, "uop_req after the last instruction");
      end
    end

    $display("%0d instructions run, %0d errors", n_inst, errors);
    if (errors == 0 && !run_aborted) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule
